// ==== source/rv_pkg.sv ====
// rv_pkg
// shared types for the five-stage rv32i subset core: opcode and alu
// encodings, the control bundle and the payload of every pipeline register
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [31:0][xlen-1:0] reg_file_t; // x31 down to x0

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_t;

  localparam word_t halt_code = 32'd10; // a0-style exit code in x17
  localparam reg_idx_t ecall_reg = 5'd17;

  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic alu_src;    // second operand is the immediate
    logic is_branch;
    logic is_halt;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic [2:0] funct3;
    logic     funct7;     // instr bit 30
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_result;
    word_t    load_data;
    reg_idx_t rd;
  } mem_wb_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    word_t    value;
  } wb_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    word_t    alu_result;
  } fwd_t;

endpackage

// ==== source/pipe_reg.sv ====
// pipe_reg
// pipeline register for any payload type; bubble clears it,
// hold keeps the current value, bubble wins over hold
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      q <= '0; // all control bits low
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
// fetch_stage
// program counter, instruction memory and the if/id register
// memory is loaded through a word port while reset is held
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
  parameter int imem_words = 256
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   flush,
  input  word_t  branch_target,
  input  logic   load_en,
  input  word_t  load_addr,
  input  word_t  load_data,
  output if_id_t if_id
);

  localparam int aw = $clog2(imem_words);

  word_t  imem [imem_words];
  word_t  pc;
  if_id_t fetched;

  always_ff @(posedge clk) begin
    if (reset && load_en) begin
      imem[load_addr[aw-1:0]] <= load_data; // load_addr is a word index
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (flush) begin
      pc <= branch_target; // redirect from execute
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign fetched.pc    = pc;
  assign fetched.instr = imem[pc[aw+1:2]];

  pipe_reg #(.payload_t(if_id_t)) i_if_id_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (stall),
    .bubble (flush),
    .d      (fetched),
    .q      (if_id)
  );

endmodule

// ==== source/register_file.sv ====
// register_file
// 32 x 32-bit registers, x0 reads zero; the register written this
// cycle is bypassed to the read ports; all registers visible on print_reg
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_idx_t  rs1,
  input  reg_idx_t  rs2,
  input  wb_t       wb,
  output word_t     rs1_data,
  output word_t     rs2_data,
  output reg_file_t print_reg
);

  reg_file_t regs;
  logic      wr_live; // a real write this cycle

  assign wr_live = wb.en && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else if (wr_live) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // write-through so decode sees the value retiring in writeback
  assign rs1_data = (wr_live && wb.rd == rs1) ? wb.value : regs[rs1];
  assign rs2_data = (wr_live && wb.rd == rs2) ? wb.value : regs[rs2];

  assign print_reg = regs;

endmodule

// ==== source/decode_stage.sv ====
// decode_stage
// splits the instruction, decodes control, builds i/s/b immediates,
// turns ecall into a read of x17 for the halt check, and feeds id/ex
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  if_id_t   if_id,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  logic     stall,
  input  logic     flush,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     uses_rs2,
  output logic     is_ecall,
  output id_ex_t   id_ex
);

  opcode_t opcode;
  word_t   instr;
  ctrl_t   ctrl;
  word_t   imm;
  id_ex_t  decoded;

  assign instr  = if_id.instr;
  assign opcode = opcode_t'(instr[6:0]);

  assign is_ecall = (opcode == SYSTEM) && (instr[14:12] == 3'b000);
  assign rs1      = is_ecall ? ecall_reg : instr[19:15]; // x17 holds the exit code
  assign rs2      = instr[24:20];
  assign uses_rs2 = (opcode == OP) || (opcode == STORE) || (opcode == BRANCH);

  always_comb begin
    ctrl = '0; // unknown opcode or zero word is a bubble
    case (opcode)
      OP: ctrl.reg_write = 1'b1;
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      BRANCH: ctrl.is_branch = 1'b1;
      SYSTEM: ctrl.is_halt = is_ecall && (rs1_data == halt_code);
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      STORE:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BRANCH:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                      instr[11:8], 1'b0};
      default: imm = {{20{instr[31]}}, instr[31:20]}; // i-type
    endcase
  end

  assign decoded.ctrl    = ctrl;
  assign decoded.pc      = if_id.pc;
  assign decoded.rs1_val = rs1_data;
  assign decoded.rs2_val = rs2_data;
  assign decoded.imm     = imm;
  assign decoded.rs1     = rs1;
  assign decoded.rs2     = rs2;
  assign decoded.rd      = instr[11:7];
  assign decoded.funct3  = instr[14:12];
  assign decoded.funct7  = instr[30];

  pipe_reg #(.payload_t(id_ex_t)) i_id_ex_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (1'b0),
    .bubble (stall || flush), // stalled slot goes down as a bubble
    .d      (decoded),
    .q      (id_ex)
  );

endmodule

// ==== source/hazard_unit.sv ====
// hazard_unit
// stalls decode on a load-use pair or on an ecall whose x17 is still
// being produced in execute or memory; a taken branch becomes a flush
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     uses_rs2,
  input  logic     is_ecall,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  logic     branch_taken,
  output logic     stall,
  output logic     flush
);

  logic load_use;
  logic ecall_wait;

  // load result only exists after memory, so one slot of delay
  assign load_use = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                    ((id_ex.rd == rs1) || (uses_rs2 && id_ex.rd == rs2));

  // halt compare happens in decode, wait until x17 reaches writeback
  assign ecall_wait = is_ecall &&
                      ((id_ex.ctrl.reg_write && id_ex.rd == ecall_reg) ||
                       (ex_mem.ctrl.reg_write && ex_mem.rd == ecall_reg));

  assign stall = load_use || ecall_wait;
  assign flush = branch_taken; // predicted not taken

endmodule

// ==== source/execute_stage.sv ====
// execute_stage
// operand forwarding from memory and writeback, alu control and alu,
// branch compare and target, and the ex/mem register
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  id_ex_t  id_ex,
  input  fwd_t    mem_fwd,
  input  wb_t     wb,
  output logic    branch_taken,
  output word_t   branch_target,
  output ex_mem_t ex_mem
);

  word_t   fwd_a;
  word_t   fwd_b;
  word_t   alu_b;
  word_t   alu_result;
  alu_op_t alu_op;
  logic    cond;
  ex_mem_t executed;

  // memory stage is the newer producer and overrides writeback
  function automatic word_t forward(input reg_idx_t idx, input word_t reg_val,
                                    input fwd_t mem_src, input wb_t wb_src);
    word_t val;
    val = reg_val;
    if (wb_src.en && wb_src.rd != '0 && wb_src.rd == idx) val = wb_src.value;
    if (mem_src.en && mem_src.rd != '0 && mem_src.rd == idx) val = mem_src.alu_result;
    return val;
  endfunction

  assign fwd_a = forward(id_ex.rs1, id_ex.rs1_val, mem_fwd, wb);
  assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val, mem_fwd, wb);
  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  always_comb begin
    if (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write) begin
      alu_op = ALU_ADD; // address calc
    end else begin
      case (id_ex.funct3)
        3'b000:  alu_op = (!id_ex.ctrl.alu_src && id_ex.funct7) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op = ALU_SLL;
        3'b010:  alu_op = ALU_SLT;
        3'b100:  alu_op = ALU_XOR;
        3'b101:  alu_op = ALU_SRL;
        3'b110:  alu_op = ALU_OR;
        3'b111:  alu_op = ALU_AND;
        default: alu_op = ALU_ADD;
      endcase
    end
  end

  always_comb begin
    case (alu_op)
      ALU_SUB: alu_result = fwd_a - alu_b;
      ALU_AND: alu_result = fwd_a & alu_b;
      ALU_OR:  alu_result = fwd_a | alu_b;
      ALU_XOR: alu_result = fwd_a ^ alu_b;
      ALU_SLT: alu_result = {31'b0, $signed(fwd_a) < $signed(alu_b)};
      ALU_SLL: alu_result = fwd_a << alu_b[4:0];
      ALU_SRL: alu_result = fwd_a >> alu_b[4:0];
      default: alu_result = fwd_a + alu_b;
    endcase
  end

  always_comb begin
    case (id_ex.funct3)
      3'b000:  cond = (fwd_a == fwd_b);                 // beq
      3'b001:  cond = (fwd_a != fwd_b);                 // bne
      3'b100:  cond = ($signed(fwd_a) < $signed(fwd_b));  // blt
      3'b101:  cond = ($signed(fwd_a) >= $signed(fwd_b)); // bge
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken  = id_ex.ctrl.is_branch && cond;
  assign branch_target = id_ex.pc + id_ex.imm;

  assign executed.ctrl       = id_ex.ctrl;
  assign executed.alu_result = alu_result;
  assign executed.store_data = fwd_b; // store value after forwarding
  assign executed.rd         = id_ex.rd;

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (1'b0),
    .bubble (1'b0),
    .d      (executed),
    .q      (ex_mem)
  );

endmodule

// ==== source/memory_stage.sv ====
// memory_stage
// word-addressed data memory, mem/wb register, writeback select
// and the sticky halt flag
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
  parameter int dmem_words = 256
) (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output fwd_t    mem_fwd,
  output wb_t     wb,
  output logic    is_halted
);

  localparam int aw = $clog2(dmem_words);

  word_t    dmem [dmem_words];
  logic [aw-1:0] idx;
  mem_wb_t  accessed;
  mem_wb_t  mem_wb;

  assign idx = ex_mem.alu_result[aw+1:2]; // byte address to word index

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) dmem[i] <= '0;
    end else if (ex_mem.ctrl.mem_write) begin
      dmem[idx] <= ex_mem.store_data;
    end
  end

  // loads are not ready here, only alu results go back to execute
  assign mem_fwd.en         = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_to_reg;
  assign mem_fwd.rd         = ex_mem.rd;
  assign mem_fwd.alu_result = ex_mem.alu_result;

  assign accessed.ctrl       = ex_mem.ctrl;
  assign accessed.alu_result = ex_mem.alu_result;
  assign accessed.load_data  = dmem[idx]; // async read
  assign accessed.rd         = ex_mem.rd;

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (1'b0),
    .bubble (1'b0),
    .d      (accessed),
    .q      (mem_wb)
  );

  assign wb.en    = mem_wb.ctrl.reg_write;
  assign wb.rd    = mem_wb.rd;
  assign wb.value = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (mem_wb.ctrl.is_halt) begin
      is_halted <= 1'b1; // stays until reset
    end
  end

endmodule

// ==== source/pipelined_core.sv ====
// pipelined_core
// five-stage in-order rv32i subset core: fetch, decode, execute,
// memory, writeback; instruction memory loads while reset is high
`timescale 1ns/1ps

module pipelined_core import rv_pkg::*; #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      load_en,
  input  word_t     load_addr,
  input  word_t     load_data,
  output logic      is_halted,
  output reg_file_t print_reg
);

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  fwd_t     mem_fwd;
  wb_t      wb;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     uses_rs2;
  logic     is_ecall;
  logic     stall;
  logic     flush;
  logic     branch_taken;
  word_t    branch_target;

  fetch_stage #(.imem_words(imem_words)) i_fetch_stage (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .flush         (flush),
    .branch_target (branch_target),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .if_id         (if_id)
  );

  decode_stage i_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .if_id    (if_id),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .stall    (stall),
    .flush    (flush),
    .rs1      (rs1),
    .rs2      (rs2),
    .uses_rs2 (uses_rs2),
    .is_ecall (is_ecall),
    .id_ex    (id_ex)
  );

  register_file i_register_file (
    .clk       (clk),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .wb        (wb),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .print_reg (print_reg)
  );

  hazard_unit i_hazard_unit (
    .rs1          (rs1),
    .rs2          (rs2),
    .uses_rs2     (uses_rs2),
    .is_ecall     (is_ecall),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .branch_taken (branch_taken),
    .stall        (stall),
    .flush        (flush)
  );

  execute_stage i_execute_stage (
    .clk           (clk),
    .reset         (reset),
    .id_ex         (id_ex),
    .mem_fwd       (mem_fwd),
    .wb            (wb),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .ex_mem        (ex_mem)
  );

  memory_stage #(.dmem_words(dmem_words)) i_memory_stage (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_fwd   (mem_fwd),
    .wb        (wb),
    .is_halted (is_halted)
  );

endmodule

// ==== test/core_programs.svh ====
// core_programs
// program table for the core testbench: hand-encoded rv32i words,
// zero padded, and the register values expected once the core halts
// every program ends with addi x17,x0,10 and ecall
`ifndef core_programs_svh
`define core_programs_svh

localparam int num_programs = 4;
localparam int max_words    = 24;
localparam int max_checks   = 12;

typedef struct packed {
  reg_idx_t idx;
  word_t    value;
} reg_check_t;

string prog_name [num_programs] = '{"alu_forwarding", "load_store", "branches", "ecall_and_x0"};

word_t prog_words [num_programs][max_words] = '{
  // addi x1,5 | addi x2,x1,3 | add x3,x2,x1 | sub x4,x3,x1 | slli x5,x4,2 | or x6,x5,x3
  // xori x7,x6,15 | and x8,x7,x6 | srli x9,x6,2 | addi x10,-7 | slt x11,x10,x9
  // slti x12,x10,-6 | sll x13,x9,x1 | srl x14,x10,x1 | andi x15,x10,0xf0
  '{32'h00500093, 32'h00308113, 32'h001101B3, 32'h40118233, 32'h00221293, 32'h0032E333,
    32'h00F34393, 32'h0063F433, 32'h00235493, 32'hFF900513, 32'h009525B3, 32'hFFA52613,
    32'h001496B3, 32'h00155733, 32'h0F057793, 32'h00A00893, 32'h00000073, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  // addi x1,0x40 | addi x2,123 | sw x2,0(x1) | lw x3,0(x1) | add x4,x3,x2 | addi x5,-100
  // sw x5,4(x1) | lw x6,4(x1) | sw x6,8(x1) | lw x7,8(x1) | lw x8,0x44(x0) | add x9,x7,x8
  '{32'h04000093, 32'h07B00113, 32'h0020A023, 32'h0000A183, 32'h00218233, 32'hF9C00293,
    32'h0050A223, 32'h0040A303, 32'h0060A423, 32'h0080A383, 32'h04402403, 32'h008384B3,
    32'h00A00893, 32'h00000073, 32'h0, 32'h0, 32'h0, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  // x1=5, x2=-3; taken beq/bne/blt/bge skip markers x10..x13
  // not-taken beq/blt/bge/bne fall into x14, x15, x16, x18
  '{32'h00500093, 32'hFFD00113, 32'h00108463, 32'h00100513, 32'h00209463, 32'h00100593,
    32'h00114463, 32'h00100613, 32'h0020D463, 32'h00100693, 32'h00208463, 32'h00100713,
    32'h0020C463, 32'h00100793, 32'h00115463, 32'h00100813, 32'h00109463, 32'h00100913,
    32'h00A00893, 32'h00000073, 32'h0, 32'h0, 32'h0, 32'h0},
  // addi x17,3 | ecall | addi x1,9 | add x0,x1,x1 | add x2,x0,x1 | addi x0,7
  // addi x3,x0,4 | addi x4,6 | addi x17,10 | ecall
  '{32'h00300893, 32'h00000073, 32'h00900093, 32'h00108033, 32'h00100133, 32'h00700013,
    32'h00400193, 32'h00600213, 32'h00A00893, 32'h00000073, 32'h0, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
};

// {register, value}; unused slots check x0
reg_check_t prog_checks [num_programs][max_checks] = '{
  '{'{5'd3, 32'h0000000D}, '{5'd4, 32'h00000008}, '{5'd5, 32'h00000020},
    '{5'd6, 32'h0000002D}, '{5'd7, 32'h00000022}, '{5'd8, 32'h00000020},
    '{5'd9, 32'h0000000B}, '{5'd11, 32'h00000001}, '{5'd12, 32'h00000001},
    '{5'd13, 32'h00000160}, '{5'd14, 32'h07FFFFFF}, '{5'd15, 32'h000000F0}},
  '{'{5'd1, 32'h00000040}, '{5'd2, 32'h0000007B}, '{5'd3, 32'h0000007B},
    '{5'd4, 32'h000000F6}, '{5'd5, 32'hFFFFFF9C}, '{5'd6, 32'hFFFFFF9C},
    '{5'd7, 32'hFFFFFF9C}, '{5'd8, 32'hFFFFFF9C}, '{5'd9, 32'hFFFFFF38},
    '{5'd11, 32'h00000000}, '{5'd13, 32'h00000000}, '{5'd15, 32'h00000000}},
  '{'{5'd10, 32'h00000000}, '{5'd11, 32'h00000000}, '{5'd12, 32'h00000000},
    '{5'd13, 32'h00000000}, '{5'd14, 32'h00000001}, '{5'd15, 32'h00000001},
    '{5'd16, 32'h00000001}, '{5'd18, 32'h00000001}, '{5'd3, 32'h00000000},
    '{5'd4, 32'h00000000}, '{5'd8, 32'h00000000}, '{5'd9, 32'h00000000}},
  '{'{5'd0, 32'h00000000}, '{5'd1, 32'h00000009}, '{5'd2, 32'h00000009},
    '{5'd3, 32'h00000004}, '{5'd4, 32'h00000006}, '{5'd17, 32'h0000000A},
    '{5'd14, 32'h00000000}, '{5'd15, 32'h00000000}, '{5'd16, 32'h00000000},
    '{5'd18, 32'h00000000}, '{5'd0, 32'h00000000}, '{5'd0, 32'h00000000}}
};

`endif

// ==== test/core_tb.sv ====
// core_tb
// runs each program of the table on the pipelined core: loads it while
// reset is high, releases reset, waits for halt and checks registers
`timescale 1ns/1ps

module core_tb import rv_pkg::*; ();

  localparam int half_period  = 20;   // 40 ns clock
  localparam int reset_cycles = 10;
  localparam int halt_timeout = 2000; // cycles per program
  localparam int drive_delay  = 1;    // ns after rising edge

  logic      clk;
  logic      reset;
  logic      load_en;
  word_t     load_addr;
  word_t     load_data;
  logic      is_halted;
  reg_file_t print_reg;

  `include "core_programs.svh"

  pipelined_core #(
    .imem_words (256),
    .dmem_words (256)
  ) i_pipelined_core (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .is_halted (is_halted),
    .print_reg (print_reg)
  );

  always #half_period clk = ~clk;

  task automatic stop_on_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string test_name, input string item,
                             input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected %08h, actual %08h", test_name, item, expected, actual);
      stop_on_failure();
    end
  endtask

  // reset stays high across the whole load and a few cycles more
  task automatic load_program(input int p);
    @(posedge clk);
    #drive_delay;
    reset = 1'b1;
    for (int i = 0; i < max_words; i++) begin
      load_en   = 1'b1;
      load_addr = i; // word index
      load_data = prog_words[p][i];
      @(posedge clk);
      #drive_delay;
    end
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
  endtask

  task automatic wait_for_halt(input int p);
    int cycles;
    cycles = 0;
    while (is_halted !== 1'b1) begin
      if (cycles >= halt_timeout) begin
        $display("program %s never halted within %0d cycles", prog_name[p], halt_timeout);
        stop_on_failure();
      end
      @(posedge clk);
      #drive_delay; // sample away from the edge
      cycles++;
    end
  endtask

  task automatic compare_registers(input int p);
    reg_check_t chk;
    for (int c = 0; c < max_checks; c++) begin
      chk = prog_checks[p][c];
      check_value(prog_name[p], $sformatf("x%0d", chk.idx), chk.value, print_reg[chk.idx]);
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int p = 0; p < num_programs; p++) begin
      load_program(p);
      wait_for_halt(p);
      compare_registers(p);
      $display("program %s halted, registers match", prog_name[p]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+test
source/rv_pkg.sv
source/pipe_reg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipelined_core.sv
test/core_tb.sv

// ==== Bender.yml ====
package:
  name: pipelined_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/pipe_reg.sv
      - source/fetch_stage.sv
      - source/register_file.sv
      - source/decode_stage.sv
      - source/hazard_unit.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/pipelined_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/core_tb.sv
